// ==== Bender.yml ====
package:
  name: btb_fetch

sources:
  - include_dirs:
      - include
    files:
      - verilog/btb_pkg.sv
      - verilog/btb_commit_decode.sv
      - verilog/btb_table.sv
      - verilog/btb_return_stack.sv
      - verilog/btb_fetch_pc.sv
      - verilog/btb_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/btb_tb.sv

// ==== all.f ====
+incdir+include
verilog/btb_pkg.sv
verilog/btb_commit_decode.sv
verilog/btb_table.sv
verilog/btb_return_stack.sv
verilog/btb_fetch_pc.sv
verilog/btb_top.sv
testbench/btb_tb.sv

// ==== include/btb_config.svh ====
// ====================================================================
// Build-time sizes for the branch target buffer fetch front end
// PC width, table and return stack depth, commit width, reset PC
// ====================================================================

`ifndef BTB_CONFIG_SVH
`define BTB_CONFIG_SVH

// Address and fetch group
`define BTB_PC_WIDTH      32             // Bits in a fetch address
`define BTB_FETCH_BYTES   24             // Four instructions of six bytes

// Prediction storage
`define BTB_DEPTH         64             // Direct mapped, indexed by PC[6:1]
`define BTB_RAS_DEPTH     16             // Return stack entries

// Retire side
`define BTB_COMMIT_SLOTS  4              // Instructions committed per cycle

`define BTB_RST_PC        32'hFFFC0000   // Boot ROM vector

`endif

// ==== testbench/btb_stimulus.txt ====
# cycle line: name adv branchmiss miss_pc dec_mispredict dec_pc do_call ret_pc do_ret exp_next exp_takb
# slot line:  slot index pc tgt takb grp br ret jmp, adds a commit slot to the next cycle line
seq_walk     1 0 00000000 0 00000000 0 00000000 0 fffc0018 0
seq_walk     1 0 00000000 0 00000000 0 00000000 0 fffc0030 0
seq_hold     0 0 00000000 0 00000000 0 00000000 0 fffc0048 0
seq_hold     0 0 00000000 0 00000000 0 00000000 0 fffc0048 0
seq_walk     1 0 00000000 0 00000000 0 00000000 0 fffc0048 0
slot 0 00001000 00002000 1 2 1 0 0
br_commit    1 1 00001000 0 00000000 0 00000000 0 00001000 0
slot 0 00001104 00003000 0 5 1 0 0
br_early     0 0 00000000 0 00000000 0 00000000 0 00001018 0
br_taken     0 0 00000000 0 00000000 0 00000000 0 00002000 1
br_taken     1 0 00000000 0 00000000 0 00000000 0 00002000 1
br_redir     1 1 00001104 0 00000000 0 00000000 0 00001104 0
br_not_taken 1 0 00000000 0 00000000 0 00000000 0 00003000 0
slot 1 00004010 00005000 1 1 1 0 0
slot 3 00004020 00006000 1 4 1 0 0
two_slots    0 0 00000000 0 00000000 0 00000000 0 00003018 0
two_redir    1 1 00004020 0 00000000 0 00000000 0 00004020 0
slot3_miss   0 0 00000000 0 00000000 0 00000000 0 00004038 0
two_redir    1 1 00004010 0 00000000 0 00000000 0 00004010 0
slot1_hit    0 0 00000000 0 00000000 0 00000000 0 00005000 1
alias_redir  1 1 00004090 0 00000000 0 00000000 0 00004090 0
slot 0 00007002 00000000 0 3 0 1 0
alias_miss   0 0 00000000 0 00000000 1 0000a000 0 000040a8 0
ret_call     1 1 00007002 0 00000000 1 0000b000 0 00007002 0
ret_hit      0 0 00000000 0 00000000 0 00000000 1 0000b000 0
ret_pop      1 0 00000000 0 00000000 0 00000000 0 0000a000 0
mix_redir    1 1 00001000 0 00000000 0 00000000 0 00001000 0
mix_all      0 1 00008000 1 00009000 0 00000000 0 00008000 0
mix_dec      0 0 00000000 1 00009000 0 00000000 0 00009000 0
mix_hit      0 0 00000000 0 00000000 0 00000000 0 00002000 1
mix_dec      1 0 00000000 1 00009000 0 00000000 0 00009000 0
seq_after    1 0 00000000 0 00000000 0 00000000 0 00009018 0
end

// ==== testbench/btb_tb.sv ====
// ======================================================================
// Testbench for the BTB fetch front end
// Clock and reset, stimulus file reader, next_pc, takb and PC checks
// ======================================================================

`timescale 1ns/1ps

`include "btb_config.svh"

module btb_tb;

	import btb_pkg::*;

	localparam int    CLK_PERIOD    = 40;    // ns
	localparam int    DRIVE_DLY     = 2;     // Inputs change this long after the edge
	localparam int    RESET_CYCLES  = 10;
	localparam int    RESET_TIMEOUT = 20;    // Cycles allowed to see the reset PC
	localparam int    MAX_CYCLES    = 100;   // Limit on cycle lines
	localparam int    MAX_LINES     = 300;   // Limit on all lines including comments
	localparam string STIM_FILE     = "testbench/btb_stimulus.txt";

	// DUT ports
	logic                                  clk;
	logic                                  rst;
	logic                                  advance;
	logic                                  branchmiss;
	pc_addr_t                              miss_pc;
	logic                                  dec_mispredict;
	pc_addr_t                              dec_pc;
	logic                                  do_call;
	pc_addr_t                              ret_pc;
	logic                                  do_ret;
	commit_slot_t [`BTB_COMMIT_SLOTS-1:0] commit;
	pc_addr_t                              pc;
	pc_addr_t                              next_pc;
	logic                                  hit;
	logic                                  takb;

	// Reader state
	int                                    fd;
	int                                    n;
	int                                    lines;
	int                                    cycles;
	int                                    wait_cycles;
	bit                                    done;
	string                                 tag;          // Test name or line kind
	string                                 rest;
	commit_slot_t [`BTB_COMMIT_SLOTS-1:0] staged;       // Slots for the next cycle line
	pc_addr_t                              exp_pc;       // Follows expected next_pc on advance

	btb_top btb_top_i (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_with_failure(input string text);
		$display("%s", text);
		$display("Simulation failed");
		$fatal(1, "Stopped at the first error");
	endtask

	// ==================================================================
	// Stimulus lines
	task automatic read_slot();
		int       idx;
		int       s_takb;
		int       s_grp;
		int       s_br;
		int       s_ret;
		int       s_jmp;
		pc_addr_t s_pc;
		pc_addr_t s_tgt;
		int       cnt;
		cnt = $fscanf(fd, "%d %h %h %d %d %d %d %d",
			idx, s_pc, s_tgt, s_takb, s_grp, s_br, s_ret, s_jmp);
		if (cnt != 8 || idx < 0 || idx >= `BTB_COMMIT_SLOTS)
			stop_with_failure("A slot line in the stimulus file is incomplete or out of range");
		else begin
			staged[idx].pc   = s_pc;
			staged[idx].tgt  = s_tgt;
			staged[idx].takb = s_takb[0];
			staged[idx].grp  = grp_t'(s_grp);
			staged[idx].br   = s_br[0];
			staged[idx].ret  = s_ret[0];
			staged[idx].jmp  = s_jmp[0];
		end
	endtask

	task automatic run_cycle();
		int       adv;
		int       bm;
		int       dm;
		int       call;
		int       ret;
		int       exp_takb;
		pc_addr_t miss;
		pc_addr_t dec;
		pc_addr_t rpc;
		pc_addr_t exp_next;
		int       cnt;
		cnt = $fscanf(fd, "%d %d %h %d %h %d %h %d %h %d",
			adv, bm, miss, dm, dec, call, rpc, ret, exp_next, exp_takb);
		if (cnt != 10)
			stop_with_failure($sformatf("Stimulus line for %s is incomplete", tag));
		else begin
			advance        = adv[0];   // Already DRIVE_DLY past the edge
			branchmiss     = bm[0];
			miss_pc        = miss;
			dec_mispredict = dm[0];
			dec_pc         = dec;
			do_call        = call[0];
			ret_pc         = rpc;
			do_ret         = ret[0];
			commit         = staged;
			staged         = '0;
			#(CLK_PERIOD - 2 * DRIVE_DLY);   // Sample just before the next edge
			assert (pc === exp_pc)
				else stop_with_failure($sformatf("Error %s: pc expected %h actual %h",
					tag, exp_pc, pc));
			assert (next_pc === exp_next)
				else stop_with_failure($sformatf("Error %s: next_pc expected %h actual %h",
					tag, exp_next, next_pc));
			assert (takb === exp_takb[0])
				else stop_with_failure($sformatf("Error %s: takb expected %0d actual %0d",
					tag, exp_takb[0], takb));
			if (adv[0])
				exp_pc = exp_next;   // PC loads next_pc only on advance
			@(posedge clk);
			#DRIVE_DLY;
		end
	endtask

	// ==================================================================
	// Main sequence
	initial begin
		clk            = 1'b0;
		rst            = 1'b1;
		advance        = 1'b0;
		branchmiss     = 1'b0;
		miss_pc        = '0;
		dec_mispredict = 1'b0;
		dec_pc         = '0;
		do_call        = 1'b0;
		ret_pc         = '0;
		do_ret         = 1'b0;
		commit         = '0;
		staged         = '0;
		lines          = 0;
		cycles         = 0;
		done           = 1'b0;
		fd = $fopen(STIM_FILE, "r");
		assert (fd != 0) else stop_with_failure("Could not open the stimulus file for reading");

		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;
		wait_cycles = 0;
		while (pc !== `BTB_RST_PC && wait_cycles < RESET_TIMEOUT) begin
			@(posedge clk);
			#DRIVE_DLY;
			wait_cycles++;
		end
		assert (pc === `BTB_RST_PC)
			else stop_with_failure("The PC never reached the reset address after reset");
		assert (next_pc === `BTB_RST_PC + `BTB_FETCH_BYTES)
			else stop_with_failure($sformatf("Error reset: next_pc expected %h actual %h",
				`BTB_RST_PC + `BTB_FETCH_BYTES, next_pc));
		assert (hit === 1'b0 && takb === 1'b0)
			else stop_with_failure("Table hit or takb is high right after reset");
		exp_pc = `BTB_RST_PC;

		while (!done && lines < MAX_LINES && cycles < MAX_CYCLES) begin
			lines++;
			n = $fscanf(fd, "%s", tag);
			if (n != 1)
				stop_with_failure("The stimulus file ended before its end line");
			else if (tag.substr(0, 0) == "#")
				n = $fgets(rest, fd);   // Skip comment text
			else if (tag == "slot")
				read_slot();
			else if (tag == "end")
				done = 1'b1;
			else begin
				run_cycle();
				cycles++;
			end
		end
		assert (done) else stop_with_failure("The stimulus read loop timed out");
		$fclose(fd);

		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== verilog/btb_commit_decode.sv ====
// ====================================================================
// Commit side of the BTB
// Picks the first flow-change slot and registers one table write
// ====================================================================

`timescale 1ns/1ps

`include "btb_config.svh"

module btb_commit_decode (
	input  logic                                           clk,
	input  logic                                           rst,
	input  btb_pkg::commit_slot_t [`BTB_COMMIT_SLOTS-1:0] commit,
	output logic                                           wr_en,
	output btb_pkg::btb_entry_t                            wr_entry
);

	import btb_pkg::*;

	logic       nxt_en;      // Some slot carries a branch, jump or return
	btb_entry_t nxt_entry;   // Entry built from the winning slot

	// Slot 0 has priority over later slots for the single write port
	always_comb begin
		nxt_en    = 1'b0;
		nxt_entry = '0;
		for (int i = 0; i < `BTB_COMMIT_SLOTS; i++) begin
			if (!nxt_en && (commit[i].br || commit[i].ret || commit[i].jmp)) begin
				nxt_en          = 1'b1;
				nxt_entry.valid = 1'b1;
				nxt_entry.takb  = commit[i].takb;
				nxt_entry.grp   = commit[i].grp;
				nxt_entry.ret   = commit[i].ret;
				nxt_entry.jmp   = commit[i].jmp;
				nxt_entry.pc    = commit[i].pc;   // Tag is the whole address
				nxt_entry.tgt   = commit[i].tgt;
			end
		end
	end

	// Registered write strobe
	always_ff @(posedge clk) begin
		if (rst)
			wr_en <= 1'b0;
		else
			wr_en <= nxt_en;
	end

	always_ff @(posedge clk) begin
		wr_entry <= nxt_entry;   // Only looked at when wr_en is high
	end

	// A registered write carries the valid bit
	a_commit_write: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> wr_entry.valid);

endmodule

// ==== verilog/btb_fetch_pc.sv ====
// ====================================================================
// Next fetch address choice and the program counter
// Redirect, decode fix, BTB or RAS target, else sequential group
// ====================================================================

`timescale 1ns/1ps

`include "btb_config.svh"

module btb_fetch_pc (
	input  logic                clk,
	input  logic                rst,
	input  logic                advance,          // Core takes the next group
	input  logic                branchmiss,       // Back end redirect
	input  btb_pkg::pc_addr_t   miss_pc,
	input  logic                dec_mispredict,   // Decode stage correction
	input  btb_pkg::pc_addr_t   dec_pc,
	input  logic                hit,
	input  btb_pkg::btb_entry_t rd_entry,
	input  btb_pkg::pc_addr_t   ras_top,
	output btb_pkg::pc_addr_t   pc,
	output btb_pkg::pc_addr_t   next_pc,
	output logic                takb
);

	import btb_pkg::*;

	pc_addr_t seq_pc;   // Fall through group

	assign seq_pc = pc + pc_addr_t'(`BTB_FETCH_BYTES);

	// ================================================================
	// Priority choice, computed whether or not the PC advances
	always_comb begin
		next_pc = seq_pc;
		takb    = 1'b0;
		if (branchmiss)
			next_pc = miss_pc;              // Back end wins over everything
		else if (dec_mispredict)
			next_pc = dec_pc;
		else if (hit) begin
			if (rd_entry.ret)
				next_pc = ras_top;          // Return goes to the stack top
			else begin
				next_pc = rd_entry.tgt;
				takb    = !rd_entry.jmp && rd_entry.takb;   // Plain branch only
			end
		end
	end

	// ================================================================
	// Program counter
	always_ff @(posedge clk) begin
		if (rst)
			pc <= `BTB_RST_PC;
		else if (advance)
			pc <= next_pc;
	end

	// Table, stack and redirect inputs must all resolve to a real address
	a_next_pc_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(next_pc));

endmodule

// ==== verilog/btb_pkg.sv ====
// ====================================================================
// Shared types for the branch target buffer
// Address vectors, table entry and commit slot structs
// ====================================================================

`include "btb_config.svh"

package btb_pkg;

	typedef logic [`BTB_PC_WIDTH-1:0]          pc_addr_t;    // Fetch address
	typedef logic [$clog2(`BTB_DEPTH)-1:0]     btb_index_t;  // Table index from PC[6:1]
	typedef logic [$clog2(`BTB_RAS_DEPTH)-1:0] ras_ptr_t;    // Return stack pointer
	typedef logic [2:0]                        grp_t;        // Branch slot in fetch group

	// ================================================================
	// One target table entry
	typedef struct packed {
		logic     valid;   // Entry holds a committed flow change
		logic     takb;    // Last outcome was taken
		grp_t     grp;     // Which instruction of the group branches
		logic     ret;     // Return, target comes from the stack
		logic     jmp;     // Unconditional jump
		pc_addr_t pc;      // Full branch address, used as the tag
		pc_addr_t tgt;     // Branch target
	} btb_entry_t;

	// ================================================================
	// One retiring instruction as seen from the back end
	typedef struct packed {
		pc_addr_t pc;      // Instruction address
		pc_addr_t tgt;     // Resolved target
		logic     takb;    // Resolved direction
		grp_t     grp;     // Position in its fetch group
		logic     br;      // Conditional branch
		logic     ret;     // Return
		logic     jmp;     // Jump
	} commit_slot_t;

endpackage

// ==== verilog/btb_return_stack.sv ====
// ====================================================================
// Circular return address stack
// Push on call, pop on return, top of stack for return prediction
// ====================================================================

`timescale 1ns/1ps

`include "btb_config.svh"

module btb_return_stack (
	input  logic              clk,
	input  logic              rst,
	input  logic              do_call,
	input  logic              do_ret,
	input  btb_pkg::pc_addr_t ret_pc,     // Address after the call
	output btb_pkg::pc_addr_t ras_top
);

	import btb_pkg::*;

	pc_addr_t ras [`BTB_RAS_DEPTH];   // Stack storage, oldest entries get overwritten
	ras_ptr_t ptr;                    // Next free slot
	ras_ptr_t top_idx;                // Most recent push

	// Pointer wraps naturally with its width
	always_ff @(posedge clk) begin
		if (rst)
			ptr <= '0;
		else if (do_call && !do_ret)
			ptr <= ptr + 1'b1;
		else if (do_ret && !do_call)
			ptr <= ptr - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (do_call && !do_ret)
			ras[ptr] <= ret_pc;       // Call and return together cancel
	end

	assign top_idx = ptr - 1'b1;
	assign ras_top = ras[top_idx];

	a_ptr_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(ptr));

	// A lone call shows its return address on top after the edge
	a_push_top: assert property (@(posedge clk) disable iff (rst)
		do_call && !do_ret |=> ras_top == $past(ret_pc));

endmodule

// ==== verilog/btb_table.sv ====
// ====================================================================
// Direct mapped branch target table
// Register array, full PC tag compare, combinational lookup
// ====================================================================

`timescale 1ns/1ps

`include "btb_config.svh"

module btb_table (
	input  logic                clk,
	input  logic                rst,
	input  btb_pkg::pc_addr_t   pc,         // Current fetch PC
	input  logic                wr_en,
	input  btb_pkg::btb_entry_t wr_entry,
	output logic                hit,
	output btb_pkg::btb_entry_t rd_entry
);

	import btb_pkg::*;

	btb_entry_t             mem [`BTB_DEPTH];   // Entry payload
	logic [`BTB_DEPTH-1:0]  valid_q;            // Valid bits cleared on reset
	btb_index_t             rd_idx;
	btb_index_t             wr_idx;

	// Index skips bit 0 since instructions sit on even addresses
	assign rd_idx = pc[$clog2(`BTB_DEPTH):1];
	assign wr_idx = wr_entry.pc[$clog2(`BTB_DEPTH):1];

	// ================================================================
	// Write port where the newest commit overwrites the slot
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_idx] <= wr_entry;
	end

	always_ff @(posedge clk) begin
		if (rst)
			valid_q <= '0;
		else if (wr_en)
			valid_q[wr_idx] <= wr_entry.valid;
	end

	// ================================================================
	// Lookup of the current PC
	always_comb begin
		rd_entry       = mem[rd_idx];
		rd_entry.valid = valid_q[rd_idx];   // Stored copy is stale after reset
	end

	// Aliasing PCs with the same index miss on the tag
	assign hit = rd_entry.valid && (rd_entry.pc == pc);

	// A hit entry was stored with its valid bit set
	a_hit_valid: assert property (@(posedge clk) disable iff (rst)
		hit |-> mem[rd_idx].valid);

	// A written PC hits on the very next lookup of that address
	a_write_then_hit: assert property (@(posedge clk) disable iff (rst)
		wr_en ##1 (pc == $past(wr_entry.pc)) |-> hit);

endmodule

// ==== verilog/btb_top.sv ====
// ====================================================================
// BTB fetch front end top level
// Commit decode, target table, return stack and PC selection
// ====================================================================

`timescale 1ns/1ps

`include "btb_config.svh"

module btb_top (
	input  logic                                           clk,
	input  logic                                           rst,
	input  logic                                           advance,
	input  logic                                           branchmiss,
	input  btb_pkg::pc_addr_t                              miss_pc,
	input  logic                                           dec_mispredict,
	input  btb_pkg::pc_addr_t                              dec_pc,
	input  logic                                           do_call,
	input  btb_pkg::pc_addr_t                              ret_pc,
	input  logic                                           do_ret,
	input  btb_pkg::commit_slot_t [`BTB_COMMIT_SLOTS-1:0] commit,
	output btb_pkg::pc_addr_t                              pc,
	output btb_pkg::pc_addr_t                              next_pc,
	output logic                                           hit,
	output logic                                           takb
);

	import btb_pkg::*;

	logic       wr_en;      // Table write from retire
	btb_entry_t wr_entry;
	btb_entry_t rd_entry;   // Entry at the current PC index
	pc_addr_t   ras_top;

	// ================================================================
	// Decode, pick the table update from the commit group
	btb_commit_decode btb_commit_decode_i (
		.clk      (clk),
		.rst      (rst),
		.commit   (commit),
		.wr_en    (wr_en),
		.wr_entry (wr_entry)
	);

	// ================================================================
	// Execute, target table and return stack
	btb_table btb_table_i (
		.clk      (clk),
		.rst      (rst),
		.pc       (pc),
		.wr_en    (wr_en),
		.wr_entry (wr_entry),
		.hit      (hit),
		.rd_entry (rd_entry)
	);

	btb_return_stack btb_return_stack_i (
		.clk     (clk),
		.rst     (rst),
		.do_call (do_call),
		.do_ret  (do_ret),
		.ret_pc  (ret_pc),
		.ras_top (ras_top)
	);

	// ================================================================
	// Result, next PC and the PC register
	btb_fetch_pc btb_fetch_pc_i (
		.clk            (clk),
		.rst            (rst),
		.advance        (advance),
		.branchmiss     (branchmiss),
		.miss_pc        (miss_pc),
		.dec_mispredict (dec_mispredict),
		.dec_pc         (dec_pc),
		.hit            (hit),
		.rd_entry       (rd_entry),
		.ras_top        (ras_top),
		.pc             (pc),
		.next_pc        (next_pc),
		.takb           (takb)
	);

endmodule
